//--- compile.f
iq_pkg.sv
iq_ctrl_if.sv
iq_dispatch.sv
iq_slot.sv
iq_queue.sv
iq_issue.sv
iq_top.sv
iq_tb_clk.sv
iq_chk.sv
iq_tb.sv

//--- iq_chk.sv
// Concurrent checks on the issue queue select and tail load
module iq_chk #(
	parameter int SIZE = 8
) (
	input logic            i_clk,
	input logic            i_rst,
	input logic [SIZE-1:0] i_grant,
	input logic [SIZE-1:0] i_request,
	input logic [SIZE-1:0] i_load,
	input logic            i_full
);

	a_one_grant : assert property (@(posedge i_clk) disable iff (i_rst)
		$onehot0(i_grant))
		else $error("more than one slot granted in a cycle");

	a_grant_req : assert property (@(posedge i_clk) disable iff (i_rst)
		(i_grant & ~i_request) == '0)
		else $error("grant given to a slot that does not request");

	a_no_full_load : assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_load[SIZE-1] && i_full))
		else $error("tail slot loaded while the queue is full");

endmodule

bind iq_queue iq_chk #(
	.SIZE (SIZE)
) u_chk (
	.i_clk     (i_clk),
	.i_rst     (i_rst),
	.i_grant   (grant),
	.i_request (request),
	.i_load    (load),
	.i_full    (o_full)
);

//--- iq_ctrl_if.sv
// Writeback and branch broadcast bundle from the dispatch side into the queue slots
interface iq_ctrl_if;
	import iq_pkg::*;

	logic [NUM_WB-1:0]             wb_valid;
	logic [NUM_WB-1:0][PREG_W-1:0] wb_preg;    // Destination of each writeback port
	logic [BRM_W-1:0]              kill_mask;  // Mispredicted branches
	logic [BRM_W-1:0]              clear_mask; // Correctly predicted branches

	modport src (
		output wb_valid,
		output wb_preg,
		output kill_mask,
		output clear_mask
	);

	modport dst (
		input  wb_valid,
		input  wb_preg,
		input  kill_mask,
		input  clear_mask
	);

endinterface

//--- iq_dispatch.sv
// Dispatch side with a register scoreboard that sets operand readiness and forwards broadcasts
module iq_dispatch (
	input  logic                                          i_clk,
	input  logic                                          i_rst,
	input  logic                                          i_disp_valid,
	input  logic [iq_pkg::BRM_W-1:0]                      i_disp_brmask,
	input  logic [iq_pkg::TAG_W-1:0]                      i_disp_tag,
	input  logic [iq_pkg::PREG_W-1:0]                     i_disp_rd,
	input  logic [iq_pkg::PREG_W-1:0]                     i_disp_rs,
	input  logic [iq_pkg::PREG_W-1:0]                     i_disp_rt,
	input  logic [iq_pkg::NUM_WB-1:0]                     i_wb_valid,
	input  logic [iq_pkg::NUM_WB-1:0][iq_pkg::PREG_W-1:0] i_wb_preg,
	input  logic [iq_pkg::BRM_W-1:0]                      i_kill_mask,
	input  logic [iq_pkg::BRM_W-1:0]                      i_clear_mask,
	output logic                                          o_disp_valid,
	output iq_pkg::iq_entry_t                             o_disp_entry,
	iq_ctrl_if.src                                        ctrl
);
	import iq_pkg::*;

	localparam int NUM_PREG = 2 ** PREG_W;

	logic [NUM_PREG-1:0] pending;  // Set at dispatch of the producer, cleared at its writeback
	logic [NUM_PREG-1:0] wb_hit;   // Registers written back this cycle
	logic [NUM_PREG-1:0] disp_set;

	// ------------------------------------------------------------------------
	// Scoreboard

	always_comb begin
		wb_hit = '0;
		for (int w = 0; w < NUM_WB; w++) begin
			if (i_wb_valid[w]) begin
				wb_hit[i_wb_preg[w]] = 1'b1;
			end
		end
	end

	assign disp_set = {{(NUM_PREG-1){1'b0}}, i_disp_valid} << i_disp_rd;

	// A new producer of the same register outranks its old writeback
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~wb_hit) | disp_set;
		end
	end

	// ------------------------------------------------------------------------
	// Entry build with writeback bypass

	always_comb begin
		o_disp_entry.brmask = i_disp_brmask;
		o_disp_entry.tag    = i_disp_tag;
		o_disp_entry.rd     = i_disp_rd;
		o_disp_entry.rs     = i_disp_rs;
		o_disp_entry.rt     = i_disp_rt;
		o_disp_entry.rs_rdy = !pending[i_disp_rs] || wb_hit[i_disp_rs];
		o_disp_entry.rt_rdy = !pending[i_disp_rt] || wb_hit[i_disp_rt];
	end

	assign o_disp_valid = i_disp_valid; // Same cycle, the tail slot catches it

	// Broadcasts go to every slot unchanged
	assign ctrl.wb_valid   = i_wb_valid;
	assign ctrl.wb_preg    = i_wb_preg;
	assign ctrl.kill_mask  = i_kill_mask;
	assign ctrl.clear_mask = i_clear_mask;

endmodule

//--- iq_issue.sv
// Issue register that presents the granted instruction for one cycle and drops killed ones
module iq_issue (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic                     i_grant_valid,
	input  iq_pkg::iq_issue_t        i_grant_entry,
	input  logic [iq_pkg::BRM_W-1:0] i_kill_mask,
	output logic                     o_issue_valid,
	output iq_pkg::iq_issue_t        o_issue_entry
);
	import iq_pkg::*;

	logic      valid_q;
	iq_issue_t entry_q;
	logic      kill_in;
	logic      kill_held;

	assign kill_in   = |(i_grant_entry.brmask & i_kill_mask);
	assign kill_held = |(entry_q.brmask & i_kill_mask);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_grant_valid && !kill_in; // A single cycle, nothing holds it longer
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_grant_valid) begin
			entry_q <= i_grant_entry;
		end
	end

	// Kill during the output cycle still wins
	assign o_issue_valid = valid_q && !kill_held;
	assign o_issue_entry = entry_q;

endmodule

//--- iq_pkg.sv
// Issue queue package with register, tag and branch mask widths and the entry structs
package iq_pkg;

	localparam int PREG_W = 6; // Physical register index
	localparam int TAG_W  = 4;
	localparam int BRM_W  = 4; // One bit per unresolved branch
	localparam int NUM_WB = 2; // Writeback ports broadcast each cycle

	// ------------------------------------------------------------------------
	// Queue entry as it leaves dispatch and sits in a slot
	typedef struct packed {
		logic [BRM_W-1:0]  brmask;
		logic [TAG_W-1:0]  tag;
		logic [PREG_W-1:0] rd;
		logic [PREG_W-1:0] rs;
		logic [PREG_W-1:0] rt;
		logic              rs_rdy;
		logic              rt_rdy;
	} iq_entry_t;

	// Issued instruction, the ready bits are of no use past the queue
	typedef struct packed {
		logic [BRM_W-1:0]  brmask;
		logic [TAG_W-1:0]  tag;
		logic [PREG_W-1:0] rd;
		logic [PREG_W-1:0] rs;
		logic [PREG_W-1:0] rt;
	} iq_issue_t;

	function automatic iq_issue_t to_issue(input iq_entry_t e);
		iq_issue_t s;
		s.brmask = e.brmask;
		s.tag    = e.tag;
		s.rd     = e.rd;
		s.rs     = e.rs;
		s.rt     = e.rt;
		return s;
	endfunction

endpackage

//--- iq_queue.sv
// Collapsing issue queue of SIZE slots that grants the oldest entry once it is ready
module iq_queue #(
	parameter int SIZE = 8
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_disp_valid,
	input  iq_pkg::iq_entry_t i_disp_entry,
	output logic              o_full,
	output logic              o_grant_valid,
	output iq_pkg::iq_issue_t o_grant_entry,
	iq_ctrl_if.dst            ctrl
);
	import iq_pkg::*;

	localparam int IDX_W = $clog2(SIZE);

	iq_entry_t        slot_entry [SIZE];
	iq_entry_t        load_entry [SIZE];
	logic [SIZE-1:0]  load;
	logic [SIZE-1:0]  shift;
	logic [SIZE-1:0]  grant;
	logic [SIZE-1:0]  occupied;
	logic [SIZE-1:0]  request;
	logic [SIZE-1:0]  vacate;
	logic [SIZE-1:0]  free;     // Empty now, or emptied by grant or kill this cycle
	logic [IDX_W-1:0] oldest;

	assign free = ~occupied | vacate;

	// ------------------------------------------------------------------------
	// Slot chain with the oldest entry in slot 0

	genvar i;
	generate
		for (i = 0; i < SIZE; i++) begin : g_slot
			if (i == SIZE - 1) begin : g_tail
				assign load[i]       = i_disp_valid;
				assign load_entry[i] = i_disp_entry;
			end else begin : g_body
				assign load[i]       = shift[i+1];
				assign load_entry[i] = slot_entry[i+1];
			end

			if (i == 0) begin : g_head
				assign shift[i] = 1'b0;
			end else begin : g_move
				assign shift[i] = occupied[i] && !grant[i] && free[i-1];
			end

			iq_slot u_slot (
				.i_clk        (i_clk),
				.i_rst        (i_rst),
				.i_load       (load[i]),
				.i_load_entry (load_entry[i]),
				.i_shift      (shift[i]),
				.i_grant      (grant[i]),
				.o_entry      (slot_entry[i]),
				.o_occupied   (occupied[i]),
				.o_request    (request[i]),
				.o_vacate     (vacate[i]),
				.ctrl         (ctrl)
			);
		end
	endgenerate

	// The tail frees up when its entry moves down, issues or dies
	assign o_full = occupied[SIZE-1] && !vacate[SIZE-1] && !shift[SIZE-1];

	// ------------------------------------------------------------------------
	// Oldest-first select where a younger ready entry never passes a blocked one

	always_comb begin
		oldest = '0;
		for (int j = SIZE - 1; j >= 0; j--) begin
			if (occupied[j]) begin
				oldest = IDX_W'(j);
			end
		end
		grant = '0;
		if (request[oldest]) begin
			grant[oldest] = 1'b1;
		end
	end

	assign o_grant_valid = |grant;

	always_comb begin
		o_grant_entry        = to_issue(slot_entry[oldest]);
		o_grant_entry.brmask = slot_entry[oldest].brmask & ~ctrl.clear_mask; // Clears of this cycle
	end

endmodule

//--- iq_slot.sv
// One collapsing queue slot holding an entry under wakeup, kill and branch mask clear
module iq_slot (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_load,
	input  iq_pkg::iq_entry_t i_load_entry,
	input  logic              i_shift,      // Held entry moves to the slot below
	input  logic              i_grant,
	output iq_pkg::iq_entry_t o_entry,
	output logic              o_occupied,
	output logic              o_request,
	output logic              o_vacate,
	iq_ctrl_if.dst            ctrl
);
	import iq_pkg::*;

	logic      valid;
	iq_entry_t entry;
	iq_entry_t held_next;
	iq_entry_t load_next;
	logic      kill_held;
	logic      kill_load;

	// Wakeup of either operand and removal of resolved branch bits
	function automatic iq_entry_t update(
		input iq_entry_t                     e,
		input logic [NUM_WB-1:0]             wb_valid,
		input logic [NUM_WB-1:0][PREG_W-1:0] wb_preg,
		input logic [BRM_W-1:0]              clear_mask
	);
		iq_entry_t u;
		u = e;
		for (int w = 0; w < NUM_WB; w++) begin
			if (wb_valid[w] && wb_preg[w] == e.rs) begin
				u.rs_rdy = 1'b1;
			end
			if (wb_valid[w] && wb_preg[w] == e.rt) begin
				u.rt_rdy = 1'b1;
			end
		end
		u.brmask = e.brmask & ~clear_mask;
		return u;
	endfunction

	// ------------------------------------------------------------------------
	// Next state of the held and the incoming entry

	assign held_next = update(entry, ctrl.wb_valid, ctrl.wb_preg, ctrl.clear_mask);
	assign load_next = update(i_load_entry, ctrl.wb_valid, ctrl.wb_preg, ctrl.clear_mask);

	assign kill_held = |(entry.brmask & ctrl.kill_mask);
	assign kill_load = |(i_load_entry.brmask & ctrl.kill_mask); // Killed on the way in

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			valid <= 1'b0;
		end else if (i_load) begin
			valid <= !kill_load;
		end else if (o_vacate || i_shift) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_load) begin
			entry <= load_next;
		end else begin
			entry <= held_next;
		end
	end

	// ------------------------------------------------------------------------
	// Status toward the select logic

	assign o_entry    = entry;
	assign o_occupied = valid;
	assign o_request  = valid && entry.rs_rdy && entry.rt_rdy;
	assign o_vacate   = valid && (i_grant || kill_held); // Moves down are not counted here

endmodule

//--- iq_tb.sv
// Directed testbench for the issue queue with an in-order model of expected issues
module iq_tb;
	import iq_pkg::*;

	localparam int SIZE      = 8;
	localparam int NUM_TESTS = 6;

	logic                         clk;
	logic                         rst;
	logic                         disp_valid;
	logic [BRM_W-1:0]             disp_brmask;
	logic [TAG_W-1:0]             disp_tag;
	logic [PREG_W-1:0]            disp_rd;
	logic [PREG_W-1:0]            disp_rs;
	logic [PREG_W-1:0]            disp_rt;
	logic [NUM_WB-1:0]            wb_valid;
	logic [NUM_WB-1:0][PREG_W-1:0] wb_preg;
	logic [BRM_W-1:0]             kill_mask;
	logic [BRM_W-1:0]             clear_mask;
	logic                         full;
	logic                         issue_valid;
	logic [BRM_W-1:0]             issue_brmask;
	logic [TAG_W-1:0]             issue_tag;
	logic [PREG_W-1:0]            issue_rd;
	logic [PREG_W-1:0]            issue_rs;
	logic [PREG_W-1:0]            issue_rt;
	int                           error_count;

	iq_issue_t expected [$]; // Oldest instruction still to issue at the front

	iq_tb_clk #(.PERIOD(8), .RST_CYCLES(2)) u_clk (.o_clk(clk), .o_rst(rst));

	iq_top #(.SIZE(SIZE)) i_dut (
		.i_clk          (clk),
		.i_rst          (rst),
		.i_disp_valid   (disp_valid),
		.i_disp_brmask  (disp_brmask),
		.i_disp_tag     (disp_tag),
		.i_disp_rd      (disp_rd),
		.i_disp_rs      (disp_rs),
		.i_disp_rt      (disp_rt),
		.i_wb_valid     (wb_valid),
		.i_wb_preg      (wb_preg),
		.i_kill_mask    (kill_mask),
		.i_clear_mask   (clear_mask),
		.o_full         (full),
		.o_issue_valid  (issue_valid),
		.o_issue_brmask (issue_brmask),
		.o_issue_tag    (issue_tag),
		.o_issue_rd     (issue_rd),
		.o_issue_rs     (issue_rs),
		.o_issue_rt     (issue_rt)
	);

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus

	task automatic drive_idle(input logic [1:0] wv, input logic [5:0] wp,
		input logic [3:0] km, input logic [3:0] cm);
		@(posedge clk);
		disp_valid <= 1'b0;
		wb_valid   <= wv;
		wb_preg    <= {6'd0, wp};
		kill_mask  <= km;
		clear_mask <= cm;
		for (int k = expected.size() - 1; k >= 0; k--) begin
			if (|(expected[k].brmask & km)) begin
				expected.delete(k);
			end else begin
				expected[k].brmask = expected[k].brmask & ~cm;
			end
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_idle(2'b00, 6'd0, 4'd0, 4'd0);
	endtask

	// The strobe follows an idle cycle that saw o_full low, so the tail is empty when it lands
	task automatic dispatch(input logic [3:0] bm, input logic [3:0] tag, input logic [5:0] rd,
		input logic [5:0] rs, input logic [5:0] rt, input logic [1:0] wv, input logic [5:0] wp);
		iq_issue_t e;
		drive_idle(2'b00, 6'd0, 4'd0, 4'd0);
		@(negedge clk);
		while (full) begin
			drive_idle(2'b00, 6'd0, 4'd0, 4'd0);
			@(negedge clk);
		end
		@(posedge clk);
		disp_valid  <= 1'b1;
		disp_brmask <= bm;
		disp_tag    <= tag;
		disp_rd     <= rd;
		disp_rs     <= rs;
		disp_rt     <= rt;
		wb_valid    <= wv;
		wb_preg     <= {6'd0, wp};
		kill_mask   <= '0;
		clear_mask  <= '0;
		e = '{brmask: bm, tag: tag, rd: rd, rs: rs, rt: rt};
		expected.push_back(e);
	endtask

	task automatic drain();
		while (expected.size() != 0) begin
			idle_cycles(1);
		end
		idle_cycles(4);
	endtask

	// ------------------------------------------------------------------------
	// The monitor compares every issue with the model in order

	always @(negedge clk) begin
		if (!rst && issue_valid) begin
			if (expected.size() == 0) begin
				$display("An instruction issued at time %0t that was not expected", $time);
				$display("SIMULATION FAILED");
				$fatal(1);
			end else begin
				check_eq("issued instruction",
					{issue_brmask, issue_tag, issue_rd, issue_rs, issue_rt}, expected[0]);
				expected.pop_front();
			end
		end
	end

	// ------------------------------------------------------------------------
	// Registers 50 and 51 are never written and stay ready in every test

	task automatic test_reset();
		@(negedge clk);
		check_eq("o_issue_valid after reset", issue_valid, 0);
		check_eq("o_full after reset", full, 0);
	endtask

	task automatic test_back_to_back();
		for (int k = 0; k < 6; k++) begin
			dispatch(4'd0, 4'(k), 6'(k + 1), 6'd50, 6'd51, 2'b00, 6'd0);
		end
		drain();
	endtask

	task automatic test_dependency();
		dispatch(4'd0, 4'd6, 6'd10, 6'd50, 6'd51, 2'b00, 6'd0);
		dispatch(4'd0, 4'd7, 6'd11, 6'd10, 6'd50, 2'b00, 6'd0); // Waits on the producer
		dispatch(4'd0, 4'd8, 6'd12, 6'd50, 6'd51, 2'b00, 6'd0);
		idle_cycles(12);
		check_eq("instructions held behind a pending operand", expected.size(), 2);
		drive_idle(2'b01, 6'd10, 4'd0, 4'd0);
		drain();
	endtask

	task automatic test_bypass();
		dispatch(4'd0, 4'd9, 6'd20, 6'd50, 6'd51, 2'b00, 6'd0);
		dispatch(4'd0, 4'd10, 6'd21, 6'd20, 6'd50, 2'b01, 6'd20);
		drain();
	endtask

	task automatic test_kill();
		dispatch(4'd0, 4'd11, 6'd30, 6'd50, 6'd51, 2'b00, 6'd0);
		dispatch(4'b0001, 4'd12, 6'd31, 6'd30, 6'd50, 2'b00, 6'd0); // Blocks the rest
		dispatch(4'b0010, 4'd13, 6'd32, 6'd50, 6'd51, 2'b00, 6'd0);
		dispatch(4'b0100, 4'd14, 6'd33, 6'd50, 6'd51, 2'b00, 6'd0);
		dispatch(4'b0000, 4'd15, 6'd34, 6'd50, 6'd51, 2'b00, 6'd0);
		idle_cycles(12);
		check_eq("entries held before the kill", expected.size(), 4);
		drive_idle(2'b00, 6'd0, 4'd0, 4'b0100);
		drive_idle(2'b00, 6'd0, 4'b0101, 4'd0);
		drain();
		drive_idle(2'b01, 6'd30, 4'd0, 4'd0);
		idle_cycles(2);
	endtask

	task automatic test_full();
		dispatch(4'd0, 4'd0, 6'd40, 6'd50, 6'd51, 2'b00, 6'd0);
		for (int k = 0; k < SIZE; k++) begin
			dispatch(4'd0, 4'(k + 1), 6'(k + 41), 6'd40, 6'd50, 2'b00, 6'd0);
		end
		idle_cycles(2 * SIZE + 4);
		@(negedge clk);
		check_eq("o_full with every slot blocked", full, 1);
		check_eq("blocked instructions", expected.size(), SIZE);
		drive_idle(2'b01, 6'd40, 4'd0, 4'd0);
		drain();
		@(negedge clk);
		check_eq("o_full after release", full, 0);
	endtask

	// ------------------------------------------------------------------------

	initial begin
		error_count = 0;
		disp_valid  = 1'b0;
		disp_brmask = '0;
		disp_tag    = '0;
		disp_rd     = '0;
		disp_rs     = '0;
		disp_rt     = '0;
		wb_valid    = '0;
		wb_preg     = '0;
		kill_mask   = '0;
		clear_mask  = '0;
		while (rst !== 1'b0) @(posedge clk);
		test_reset();
		test_back_to_back();
		test_dependency();
		test_bypass();
		test_kill();
		test_full();
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		repeat (NUM_TESTS * 200) @(posedge clk);
		$display("Timeout: the tests did not finish in time");
		$display("SIMULATION FAILED");
		$fatal(1);
	end

endmodule

//--- iq_tb_clk.sv
// Testbench clock and reset generator for the issue queue
module iq_tb_clk #(
	parameter int PERIOD     = 8,
	parameter int RST_CYCLES = 2
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

//--- iq_top.sv
// Issue queue top with dispatch scoreboard, collapsing queue and issue register
module iq_top #(
	parameter int SIZE = 8
) (
	input  logic                                          i_clk,
	input  logic                                          i_rst,
	input  logic                                          i_disp_valid,
	input  logic [iq_pkg::BRM_W-1:0]                      i_disp_brmask,
	input  logic [iq_pkg::TAG_W-1:0]                      i_disp_tag,
	input  logic [iq_pkg::PREG_W-1:0]                     i_disp_rd,
	input  logic [iq_pkg::PREG_W-1:0]                     i_disp_rs,
	input  logic [iq_pkg::PREG_W-1:0]                     i_disp_rt,
	input  logic [iq_pkg::NUM_WB-1:0]                     i_wb_valid,
	input  logic [iq_pkg::NUM_WB-1:0][iq_pkg::PREG_W-1:0] i_wb_preg,
	input  logic [iq_pkg::BRM_W-1:0]                      i_kill_mask,
	input  logic [iq_pkg::BRM_W-1:0]                      i_clear_mask,
	output logic                                          o_full,
	output logic                                          o_issue_valid,
	output logic [iq_pkg::BRM_W-1:0]                      o_issue_brmask,
	output logic [iq_pkg::TAG_W-1:0]                      o_issue_tag,
	output logic [iq_pkg::PREG_W-1:0]                     o_issue_rd,
	output logic [iq_pkg::PREG_W-1:0]                     o_issue_rs,
	output logic [iq_pkg::PREG_W-1:0]                     o_issue_rt
);
	import iq_pkg::*;

	iq_ctrl_if ctrl ();

	logic      disp_valid;
	iq_entry_t disp_entry;
	logic      grant_valid;
	iq_issue_t grant_entry;
	iq_issue_t issue_entry;

	iq_dispatch u_dispatch (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_disp_valid  (i_disp_valid),
		.i_disp_brmask (i_disp_brmask),
		.i_disp_tag    (i_disp_tag),
		.i_disp_rd     (i_disp_rd),
		.i_disp_rs     (i_disp_rs),
		.i_disp_rt     (i_disp_rt),
		.i_wb_valid    (i_wb_valid),
		.i_wb_preg     (i_wb_preg),
		.i_kill_mask   (i_kill_mask),
		.i_clear_mask  (i_clear_mask),
		.o_disp_valid  (disp_valid),
		.o_disp_entry  (disp_entry),
		.ctrl          (ctrl)
	);

	iq_queue #(
		.SIZE (SIZE)
	) u_queue (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_disp_valid  (disp_valid),
		.i_disp_entry  (disp_entry),
		.o_full        (o_full),
		.o_grant_valid (grant_valid),
		.o_grant_entry (grant_entry),
		.ctrl          (ctrl)
	);

	iq_issue u_issue (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_grant_valid (grant_valid),
		.i_grant_entry (grant_entry),
		.i_kill_mask   (i_kill_mask),
		.o_issue_valid (o_issue_valid),
		.o_issue_entry (issue_entry)
	);

	// ------------------------------------------------------------------------
	// Issued fields out as plain ports

	assign o_issue_brmask = issue_entry.brmask;
	assign o_issue_tag    = issue_entry.tag;
	assign o_issue_rd     = issue_entry.rd;
	assign o_issue_rs     = issue_entry.rs;
	assign o_issue_rt     = issue_entry.rt;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the issue queue testbench with Verilator
verilator --binary --assert -Wno-fatal --top-module iq_tb -f compile.f -o iq_sim \
	&& ./obj_dir/iq_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	|| exit 1
